//--- hdl/matmul_pkg.sv
package matmul_pkg;

  //////////////////////////////
  // Element and memory geometry
  //////////////////////////////

  // One unsigned matrix element
  localparam int DATA_WIDTH = 8;

  // Square matrix dimension, also the grid size
  localparam int MAT_SIZE = 4;

  // Word address into each row memory
  localparam int ADDR_WIDTH = 7;

  // One memory word carries a full row or column, lane 0 in the low bits
  localparam int ROW_WIDTH = MAT_SIZE * DATA_WIDTH;

  localparam int MEM_DEPTH = 128;

  //////////////////////////////
  // Controller states
  //////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    FEED,
    DRAIN,
    WRITE_C,
    FINISH
  } ctrl_state_t;

endpackage

//--- hdl/row_ram.sv
`timescale 1ns/1ps

module row_ram (
  input  logic                              clk_mem,
  input  logic [matmul_pkg::ADDR_WIDTH-1:0] addr,
  input  logic [matmul_pkg::ROW_WIDTH-1:0]  wdata,
  input  logic                              we,
  output logic [matmul_pkg::ROW_WIDTH-1:0]  rdata
);
  import matmul_pkg::*;

  // One row or column of a matrix per word
  logic [ROW_WIDTH-1:0] mem [MEM_DEPTH];

  // Single port, read-before-write
  // Read data shows up one cycle after the address
  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- hdl/systolic_pe.sv
`timescale 1ns/1ps

module systolic_pe (
  input  logic                              clk_mem,
  input  logic                              reset,
  input  logic                              clear_acc,
  input  logic [matmul_pkg::DATA_WIDTH-1:0] a_in,
  input  logic [matmul_pkg::DATA_WIDTH-1:0] b_in,
  output logic [matmul_pkg::DATA_WIDTH-1:0] a_out,
  output logic [matmul_pkg::DATA_WIDTH-1:0] b_out,
  output logic [matmul_pkg::DATA_WIDTH-1:0] acc
);
  import matmul_pkg::*;

  // Product kept to element width, so the sum wraps at 8 bits
  logic [DATA_WIDTH-1:0] prod;

  assign prod = a_in * b_in;

  // Operands move one hop per cycle
  // A goes right, B goes down
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      a_out <= '0;
      b_out <= '0;
    end else begin
      a_out <= a_in;
      b_out <= b_in;
    end
  end

  // Accumulator, cleared at the start of every run
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      acc <= '0;
    end else if (clear_acc) begin
      acc <= '0;
    end else begin
      acc <= acc + prod;
    end
  end

endmodule

//--- hdl/systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
  input  logic                             clk_mem,
  input  logic                             reset,
  input  logic                             clear_acc,
  input  logic                             feed_valid,
  input  logic [matmul_pkg::ROW_WIDTH-1:0] a_col,
  input  logic [matmul_pkg::ROW_WIDTH-1:0] b_row,
  input  logic [1:0]                       c_row_sel,
  output logic [matmul_pkg::ROW_WIDTH-1:0] c_row
);
  import matmul_pkg::*;

  // Memory words outside the feed window must not reach the cells
  logic [ROW_WIDTH-1:0]  a_gated;
  logic [ROW_WIDTH-1:0]  b_gated;

  // a_h[i][j] enters cell (i,j) from the left, b_v[i][j] from above
  logic [DATA_WIDTH-1:0] a_h      [MAT_SIZE][MAT_SIZE+1];
  logic [DATA_WIDTH-1:0] b_v      [MAT_SIZE+1][MAT_SIZE];
  logic [DATA_WIDTH-1:0] acc_grid [MAT_SIZE][MAT_SIZE];

  assign a_gated = feed_valid ? a_col : '0;
  assign b_gated = feed_valid ? b_row : '0;

  //////////////////////////////
  // Input skew
  //////////////////////////////

  // Lane l is held back l cycles so that A[i][k] and B[k][j]
  // meet in cell (i,j) on the same cycle
  for (genvar l = 0; l < MAT_SIZE; l++) begin : g_skew
    if (l == 0) begin : g_direct
      assign a_h[0][0] = a_gated[0 +: DATA_WIDTH];
      assign b_v[0][0] = b_gated[0 +: DATA_WIDTH];
    end else begin : g_delay
      logic [DATA_WIDTH-1:0] a_pipe [l];
      logic [DATA_WIDTH-1:0] b_pipe [l];

      always_ff @(posedge clk_mem) begin
        a_pipe[0] <= a_gated[l*DATA_WIDTH +: DATA_WIDTH];
        b_pipe[0] <= b_gated[l*DATA_WIDTH +: DATA_WIDTH];
        for (int s = 1; s < l; s++) begin
          a_pipe[s] <= a_pipe[s-1];
          b_pipe[s] <= b_pipe[s-1];
        end
      end

      assign a_h[l][0] = a_pipe[l-1];
      assign b_v[0][l] = b_pipe[l-1];
    end
  end

  //////////////////////////////
  // Cell grid
  //////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
      systolic_pe u_pe (
        .clk_mem   (clk_mem),
        .reset     (reset),
        .clear_acc (clear_acc),
        .a_in      (a_h[i][j]),
        .b_in      (b_v[i][j]),
        .a_out     (a_h[i][j+1]),
        .b_out     (b_v[i+1][j]),
        .acc       (acc_grid[i][j])
      );
    end
  end

  // Row i of C sits in row i of the grid, column j in lane j
  always_comb begin
    for (int j = 0; j < MAT_SIZE; j++) begin
      c_row[j*DATA_WIDTH +: DATA_WIDTH] = acc_grid[c_row_sel][j];
    end
  end

endmodule

//--- hdl/matmul_ctrl.sv
`timescale 1ns/1ps

module matmul_ctrl (
  input  logic                              clk_mem,
  input  logic                              reset,
  input  logic                              start_mat_mul,
  output logic [matmul_pkg::ADDR_WIDTH-1:0] ab_addr,
  output logic                              feed_valid,
  output logic                              clear_acc,
  output logic [matmul_pkg::ADDR_WIDTH-1:0] c_addr,
  output logic [1:0]                        c_row_sel,
  output logic                              c_we,
  output logic                              done_mat_mul
);
  import matmul_pkg::*;

  ctrl_state_t state;
  logic [2:0]  step;
  logic        last_step;

  // Phase lengths
  // FEED and WRITE_C take one step per row, DRAIN covers the
  // diagonal trip of the last wavefront down to cell (3,3)
  always_comb begin
    case (state)
      FEED, WRITE_C: last_step = (step == 3'(MAT_SIZE - 1));
      DRAIN:         last_step = (step == 3'(2 * MAT_SIZE - 2));
      default:       last_step = 1'b0;
    endcase
  end

  // Step count doubles as A/B address and as C row
  assign ab_addr   = (state == FEED) ? ADDR_WIDTH'(step[1:0]) : '0;
  assign c_addr    = (state == WRITE_C) ? ADDR_WIDTH'(step[1:0]) : '0;
  assign c_row_sel = step[1:0];

  //////////////////////////////
  // Run sequencer
  //////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      state        <= IDLE;
      step         <= '0;
      clear_acc    <= 1'b0;
      feed_valid   <= 1'b0;
      c_we         <= 1'b0;
      done_mat_mul <= 1'b0;
    end else begin
      clear_acc    <= 1'b0;
      done_mat_mul <= 1'b0;
      // Memory data for an address arrives one cycle later
      feed_valid   <= (state == FEED);
      // Lines up with the C address and row data registered in the top
      c_we         <= (state == WRITE_C);

      if (last_step) begin
        step <= '0;
      end else begin
        step <= step + 3'd1;
      end

      case (state)
        IDLE: begin
          step <= '0;
          // Start only counts here, so a pulse mid-run is dropped
          if (start_mat_mul) begin
            state     <= FEED;
            clear_acc <= 1'b1;
          end
        end
        FEED: begin
          if (last_step) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (last_step) begin
            state <= WRITE_C;
          end
        end
        WRITE_C: begin
          if (last_step) begin
            state        <= FINISH;
            done_mat_mul <= 1'b1;
          end
        end
        FINISH: begin
          step  <= '0;
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- hdl/matmul_top.sv
`timescale 1ns/1ps

module matmul_top (
  input  logic                              clk_mem,
  input  logic                              reset,
  input  logic                              enable_writing_to_mem,
  input  logic                              enable_reading_from_mem,
  input  logic [matmul_pkg::ROW_WIDTH-1:0]  data_pi,
  input  logic [matmul_pkg::ADDR_WIDTH-1:0] addr_pi,
  input  logic                              we_a,
  input  logic                              we_b,
  input  logic                              start_mat_mul,
  output logic                              done_mat_mul,
  output logic [matmul_pkg::ROW_WIDTH-1:0]  data_from_out_mat
);
  import matmul_pkg::*;

  // Host side registers
  logic                  enable_writing_reg;
  logic                  enable_reading_reg;
  logic [ADDR_WIDTH-1:0] addr_pi_reg;
  logic [ROW_WIDTH-1:0]  data_pi_reg;
  logic                  we_a_reg;
  logic                  we_b_reg;

  // Controller outputs
  logic [ADDR_WIDTH-1:0] ab_addr;
  logic                  feed_valid;
  logic                  clear_acc;
  logic [ADDR_WIDTH-1:0] c_addr;
  logic [1:0]            c_row_sel;
  logic                  c_we;

  // Memory side
  logic [ADDR_WIDTH-1:0] ab_addr_muxed;
  logic [ADDR_WIDTH-1:0] c_addr_muxed_reg;
  logic [ROW_WIDTH-1:0]  a_rdata;
  logic [ROW_WIDTH-1:0]  b_rdata;
  logic [ROW_WIDTH-1:0]  c_rdata;
  logic [ROW_WIDTH-1:0]  c_row;
  logic [ROW_WIDTH-1:0]  c_wdata_reg;

  //////////////////////////////
  // Host port registers
  //////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      enable_writing_reg <= 1'b0;
      enable_reading_reg <= 1'b0;
      addr_pi_reg        <= '0;
      we_a_reg           <= 1'b0;
      we_b_reg           <= 1'b0;
    end else begin
      enable_writing_reg <= enable_writing_to_mem;
      enable_reading_reg <= enable_reading_from_mem;
      addr_pi_reg        <= addr_pi;
      we_a_reg           <= we_a;
      we_b_reg           <= we_b;
    end
  end

  always_ff @(posedge clk_mem) begin
    data_pi_reg <= data_pi;
  end

  //////////////////////////////
  // A and B memories
  //////////////////////////////

  // Host owns the address while writing, the controller otherwise
  assign ab_addr_muxed = enable_writing_reg ? addr_pi_reg : ab_addr;

  row_ram u_mem_a (
    .clk_mem (clk_mem),
    .addr    (ab_addr_muxed),
    .wdata   (data_pi_reg),
    .we      (we_a_reg),
    .rdata   (a_rdata)
  );

  row_ram u_mem_b (
    .clk_mem (clk_mem),
    .addr    (ab_addr_muxed),
    .wdata   (data_pi_reg),
    .we      (we_b_reg),
    .rdata   (b_rdata)
  );

  //////////////////////////////
  // C memory and readback
  //////////////////////////////

  // Address and row data both take one register stage,
  // the controller delays c_we to match
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      c_addr_muxed_reg <= '0;
    end else begin
      c_addr_muxed_reg <= enable_reading_reg ? addr_pi_reg : c_addr;
    end
  end

  always_ff @(posedge clk_mem) begin
    c_wdata_reg <= c_row;
  end

  row_ram u_mem_c (
    .clk_mem (clk_mem),
    .addr    (c_addr_muxed_reg),
    .wdata   (c_wdata_reg),
    .we      (c_we),
    .rdata   (c_rdata)
  );

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      data_from_out_mat <= '0;
    end else begin
      data_from_out_mat <= c_rdata;
    end
  end

  //////////////////////////////
  // Compute core
  //////////////////////////////

  systolic_array u_systolic_array (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .clear_acc  (clear_acc),
    .feed_valid (feed_valid),
    .a_col      (a_rdata),
    .b_row      (b_rdata),
    .c_row_sel  (c_row_sel),
    .c_row      (c_row)
  );

  matmul_ctrl u_matmul_ctrl (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .ab_addr       (ab_addr),
    .feed_valid    (feed_valid),
    .clear_acc     (clear_acc),
    .c_addr        (c_addr),
    .c_row_sel     (c_row_sel),
    .c_we          (c_we),
    .done_mat_mul  (done_mat_mul)
  );

endmodule

//--- testbench/matmul_sva.sv
`timescale 1ns/1ps

module matmul_sva (
  input logic                             clk_mem,
  input logic                             reset,
  input logic                             done_mat_mul,
  input logic [matmul_pkg::ROW_WIDTH-1:0] data_from_out_mat
);

  //////////////////////////////
  // Done pulse shape
  //////////////////////////////

  // One cycle wide, never stretched
  property p_done_single;
    @(posedge clk_mem) disable iff (reset)
      done_mat_mul |=> !done_mat_mul;
  endproperty

  a_done_single: assert property (p_done_single)
    else $error("done_mat_mul stayed high for two cycles");

  // Covers the reset cycles and the first cycle after release
  a_done_reset: assert property (@(posedge clk_mem) reset |=> !done_mat_mul)
    else $error("done_mat_mul high during or right after reset");

  //////////////////////////////
  // Readback register
  //////////////////////////////

  a_out_reset: assert property (@(posedge clk_mem) $fell(reset) |-> data_from_out_mat == '0)
    else $error("data_from_out_mat not zero after reset");

endmodule

bind matmul_top matmul_sva u_matmul_sva (
  .clk_mem           (clk_mem),
  .reset             (reset),
  .done_mat_mul      (done_mat_mul),
  .data_from_out_mat (data_from_out_mat)
);

//--- testbench/matmul_tb.sv
`timescale 1ns/1ps

module matmul_tb;
  import matmul_pkg::*;

  // Five tests take a few hundred cycles, this leaves ample margin
  localparam int CYCLE_LIMIT  = 3000;
  localparam int DONE_LIMIT   = 100;
  localparam int READ_LATENCY = 3;

  logic                  clk_mem;
  logic                  reset;
  logic                  enable_writing_to_mem;
  logic                  enable_reading_from_mem;
  logic [ROW_WIDTH-1:0]  data_pi;
  logic [ADDR_WIDTH-1:0] addr_pi;
  logic                  we_a;
  logic                  we_b;
  logic                  start_mat_mul;
  logic                  done_mat_mul;
  logic [ROW_WIDTH-1:0]  data_from_out_mat;

  // Current operands, element [row][col]
  logic [DATA_WIDTH-1:0] mat_a [MAT_SIZE][MAT_SIZE];
  logic [DATA_WIDTH-1:0] mat_b [MAT_SIZE][MAT_SIZE];
  int                    read_order [MAT_SIZE];
  integer                seed;
  logic [31:0]           rnd;

  int errors       = 0;
  int rows_checked = 0;
  int done_count   = 0;
  int cycle_count  = 0;

  // Readback results waiting for the compare process
  int                   addr_q [$];
  logic [ROW_WIDTH-1:0] exp_q  [$];
  logic [ROW_WIDTH-1:0] act_q  [$];
  int                   cmp_addr;
  logic [ROW_WIDTH-1:0] cmp_exp;
  logic [ROW_WIDTH-1:0] cmp_act;

  matmul_top u_matmul_top (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .start_mat_mul           (start_mat_mul),
    .done_mat_mul            (done_mat_mul),
    .data_from_out_mat       (data_from_out_mat)
  );

  initial begin
    clk_mem = 1'b0;
    forever #50 clk_mem = ~clk_mem;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Row i of A x B, every element wraps at 8 bits
  function automatic logic [ROW_WIDTH-1:0] ref_row(input int i);
    logic [ROW_WIDTH-1:0]  row;
    logic [DATA_WIDTH-1:0] sum;
    for (int j = 0; j < MAT_SIZE; j++) begin
      sum = '0;
      for (int k = 0; k < MAT_SIZE; k++) begin
        sum = sum + mat_a[i][k] * mat_b[k][j];
      end
      row[j*DATA_WIDTH +: DATA_WIDTH] = sum;
    end
    return row;
  endfunction

  // A is stored by column, B by row
  function automatic logic [ROW_WIDTH-1:0] pack_a_col(input int k);
    logic [ROW_WIDTH-1:0] word;
    for (int i = 0; i < MAT_SIZE; i++) begin
      word[i*DATA_WIDTH +: DATA_WIDTH] = mat_a[i][k];
    end
    return word;
  endfunction

  function automatic logic [ROW_WIDTH-1:0] pack_b_row(input int k);
    logic [ROW_WIDTH-1:0] word;
    for (int j = 0; j < MAT_SIZE; j++) begin
      word[j*DATA_WIDTH +: DATA_WIDTH] = mat_b[k][j];
    end
    return word;
  endfunction

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic fill_random();
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        rnd = $random(seed);
        mat_a[i][j] = rnd[7:0];
        rnd = $random(seed);
        mat_b[i][j] = rnd[7:0];
      end
    end
  endtask

  task automatic set_identity_a();
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        mat_a[i][j] = (i == j) ? 8'd1 : 8'd0;
      end
    end
  endtask

  task automatic write_word(input logic sel_b, input int addr, input logic [ROW_WIDTH-1:0] word);
    @(negedge clk_mem);
    enable_writing_to_mem = 1'b1;
    addr_pi               = ADDR_WIDTH'(addr);
    data_pi               = word;
    we_a                  = ~sel_b;
    we_b                  = sel_b;
  endtask

  task automatic load_matrices();
    for (int k = 0; k < MAT_SIZE; k++) begin
      write_word(1'b0, k, pack_a_col(k));
      write_word(1'b1, k, pack_b_row(k));
    end
    @(negedge clk_mem);
    enable_writing_to_mem = 1'b0;
    we_a                  = 1'b0;
    we_b                  = 1'b0;
    // Last write lands two edges later
    repeat (2) @(negedge clk_mem);
  endtask

  task automatic pulse_start();
    @(negedge clk_mem);
    start_mat_mul = 1'b1;
    @(negedge clk_mem);
    start_mat_mul = 1'b0;
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    while (done_mat_mul !== 1'b1 && waited < DONE_LIMIT) begin
      @(negedge clk_mem);
      waited++;
    end
    assert (done_mat_mul === 1'b1) else begin
      errors++;
      $display("error: no done pulse within %0d cycles after start", DONE_LIMIT);
    end
  endtask

  // Back to back reads, one address per cycle, each sampled a fixed
  // READ_LATENCY edges after the edge that takes its address
  task automatic read_rows();
    for (int n = 0; n < MAT_SIZE + READ_LATENCY + 1; n++) begin
      @(negedge clk_mem);
      if (n > READ_LATENCY) begin
        addr_q.push_back(read_order[n-READ_LATENCY-1]);
        exp_q.push_back(ref_row(read_order[n-READ_LATENCY-1]));
        act_q.push_back(data_from_out_mat);
      end
      if (n < MAT_SIZE) begin
        enable_reading_from_mem = 1'b1;
        addr_pi                 = ADDR_WIDTH'(read_order[n]);
      end else begin
        enable_reading_from_mem = 1'b0;
      end
    end
  endtask

  //////////////////////////////
  // Compare and monitors
  //////////////////////////////

  always @(posedge clk_mem) begin
    while (act_q.size() > 0) begin
      cmp_addr = addr_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      cmp_act  = act_q.pop_front();
      rows_checked++;
      assert (cmp_act === cmp_exp) else begin
        errors++;
        $display("mismatch at %0t: C row %0d expected %h got %h",
                 $time, cmp_addr, cmp_exp, cmp_act);
      end
    end
  end

  always @(negedge clk_mem) begin
    if (done_mat_mul === 1'b1) begin
      done_count++;
    end
  end

  initial begin : watchdog
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_mem);
      cycle_count++;
    end
    errors++;
    $display("error: run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("summary: %0d rows checked, %0d errors", rows_checked, errors);
    $display("tests failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : stimulus
    int done_before;
    seed                    = 32'h9dad;
    reset                   = 1'b1;
    enable_writing_to_mem   = 1'b0;
    enable_reading_from_mem = 1'b0;
    data_pi                 = '0;
    addr_pi                 = '0;
    we_a                    = 1'b0;
    we_b                    = 1'b0;
    start_mat_mul           = 1'b0;
    repeat (8) @(negedge clk_mem);
    reset = 1'b0;
    repeat (2) @(negedge clk_mem);

    $display("test 1: identity times random B");
    fill_random();
    set_identity_a();
    load_matrices();
    pulse_start();
    wait_done();
    read_order = '{0, 1, 2, 3};
    read_rows();

    // Full random bytes, so most sums wrap
    $display("test 2: random A times random B");
    fill_random();
    load_matrices();
    pulse_start();
    wait_done();
    read_rows();

    $display("test 3: second run with new operands");
    fill_random();
    load_matrices();
    pulse_start();
    wait_done();
    read_rows();

    $display("test 4: start pulse during a run");
    fill_random();
    load_matrices();
    done_before = done_count;
    pulse_start();
    repeat (5) @(negedge clk_mem);
    pulse_start();
    wait_done();
    repeat (30) @(negedge clk_mem);
    assert (done_count - done_before == 1) else begin
      errors++;
      $display("mismatch at %0t: expected 1 done pulse, saw %0d",
               $time, done_count - done_before);
    end
    read_rows();

    $display("test 5: readback in order 3 0 2 1");
    read_order = '{3, 0, 2, 1};
    read_rows();

    repeat (2) @(negedge clk_mem);
    $display("summary: %0d rows checked, %0d errors", rows_checked, errors);
    if (errors == 0 && rows_checked == 5 * MAT_SIZE) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/matmul_pkg.sv
hdl/row_ram.sv
hdl/systolic_pe.sv
hdl/systolic_array.sv
hdl/matmul_ctrl.sv
hdl/matmul_top.sv
testbench/matmul_sva.sv
testbench/matmul_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the matmul testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
  -f compile.f \
  --top-module matmul_tb \
  --Mdir obj_dir \
  -o matmul_sim

./obj_dir/matmul_sim > sim.log 2>&1
cat sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation result: PASS"
else
  echo "simulation result: FAIL"
  exit 1
fi
